//--- Makefile
TOP = tbMips

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) -f sim.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and address width
`define XLEN 32

// General purpose register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- decodeControl.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module decodeControl import mipsPkg::*; (
	input  logic [`XLEN-1:0] instr,
	output ctrlT             ctrl,
	output logic [`XLEN-1:0] immediate
);

	opcodeT opcode;
	functT  funct;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct  = functT'(instr[5:0]);

	always_comb begin
		ctrl = '0;
		// Sign extension is the common case
		immediate = {{(`XLEN-16){instr[15]}}, instr[15:0]};
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg  = instr[15:11];
				case (funct)
					fnAddu:  ctrl.aluOp = aluAdd;
					fnSubu:  ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnSlt:   ctrl.aluOp = aluSlt;
					default: ctrl = '0;
				endcase
			end
			opAddiu, opLw: begin
				ctrl.aluOp    = aluAdd;
				ctrl.useImm   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead  = (opcode == opLw);
				ctrl.destReg  = instr[20:16];
			end
			opOri, opLui: begin
				ctrl.aluOp    = (opcode == opLui) ? aluLui : aluOr;
				ctrl.useImm   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.destReg  = instr[20:16];
				// Raw halfword, the ALU shifts it for lui
				immediate = {{(`XLEN-16){1'b0}}, instr[15:0]};
			end
			opSw: begin
				ctrl.aluOp    = aluAdd;
				ctrl.useImm   = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opBeq: begin
				ctrl.aluOp    = aluSub;
				ctrl.isBranch = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

//--- executeStage.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module executeStage import mipsPkg::*; (
	input  executeRegT       execute,
	input  fwdSelT           fwdA,
	input  fwdSelT           fwdB,
	input  logic [`XLEN-1:0] memResult,
	input  logic [`XLEN-1:0] wbResult,
	output logic [`XLEN-1:0] aluResult,
	output logic [`XLEN-1:0] storeData,
	output logic             branchTaken,
	output logic [`XLEN-1:0] branchTarget
);

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;

	function automatic logic [`XLEN-1:0] pickOperand(
		input fwdSelT           sel,
		input logic [`XLEN-1:0] regVal,
		input logic [`XLEN-1:0] memVal,
		input logic [`XLEN-1:0] wbVal
	);
		case (sel)
			fwdMem:  pickOperand = memVal;
			fwdWb:   pickOperand = wbVal;
			default: pickOperand = regVal;
		endcase
	endfunction

	assign opA       = pickOperand(fwdA, execute.rsVal, memResult, wbResult);
	assign storeData = pickOperand(fwdB, execute.rtVal, memResult, wbResult);
	assign opB       = execute.ctrl.useImm ? execute.imm : storeData;

	always_comb begin
		case (execute.ctrl.aluOp)
			aluAdd:  aluResult = opA + opB;
			aluSub:  aluResult = opA - opB;
			aluAnd:  aluResult = opA & opB;
			aluOr:   aluResult = opA | opB;
			aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
			aluLui:  aluResult = opB << 16;
			default: aluResult = '0;
		endcase
	end

	// beq compares the forwarded register operands, never the immediate
	assign branchTaken  = execute.ctrl.isBranch && (opA == storeData);
	assign branchTarget = execute.pcPlus4 + {execute.imm[`XLEN-3:0], 2'b00};

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module hazardUnit import mipsPkg::*; (
	input  logic [`REG_ADDR_W-1:0] decodeRs,
	input  logic [`REG_ADDR_W-1:0] decodeRt,
	input  executeRegT             execute,
	input  ctrlT                   memCtrl,
	input  ctrlT                   wbCtrl,
	input  logic                   branchTaken,
	output fwdSelT                 fwdA,
	output fwdSelT                 fwdB,
	output logic                   stall,
	output logic                   flush
);

	logic loadInExecute;

	// The younger stage wins when both hold the register
	function automatic fwdSelT pickSource(
		input logic [`REG_ADDR_W-1:0] src,
		input ctrlT                   memC,
		input ctrlT                   wbC
	);
		if (memC.regWrite && memC.destReg != '0 && memC.destReg == src) begin
			pickSource = fwdMem;
		end else if (wbC.regWrite && wbC.destReg != '0 && wbC.destReg == src) begin
			pickSource = fwdWb;
		end else begin
			pickSource = fwdReg;
		end
	endfunction

	assign fwdA = pickSource(execute.rs, memCtrl, wbCtrl);
	assign fwdB = pickSource(execute.rt, memCtrl, wbCtrl);

	assign loadInExecute = execute.ctrl.memRead && (execute.ctrl.destReg != '0);

	// Load data is only ready in writeback, so decode waits one cycle
	assign stall = loadInExecute &&
		(execute.ctrl.destReg == decodeRs || execute.ctrl.destReg == decodeRt);

	assign flush = branchTaken;

endmodule

//--- mipsPipeline.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module mipsPipeline import mipsPkg::*; (
	input  logic             clk,
	input  logic             rstN,
	output logic [`XLEN-1:0] imemAddr,
	input  logic [`XLEN-1:0] imemData,
	output logic [`XLEN-1:0] dataAddr,
	output logic [`XLEN-1:0] dataWdata,
	output logic             dataWrite,
	input  logic [`XLEN-1:0] dataRdata
);

	logic [`XLEN-1:0]       pc;
	logic [`XLEN-1:0]       pcPlus4;
	decodeRegT              decReg;
	executeRegT             exReg;
	executeRegT             exNext;
	memoryRegT              memReg;
	writebackRegT           wbReg;
	ctrlT                   decCtrl;
	logic [`XLEN-1:0]       decImm;
	logic [`REG_ADDR_W-1:0] decRs;
	logic [`REG_ADDR_W-1:0] decRt;
	logic [`XLEN-1:0]       rsVal;
	logic [`XLEN-1:0]       rtVal;
	fwdSelT                 fwdA;
	fwdSelT                 fwdB;
	logic                   stall;
	logic                   flush;
	logic [`XLEN-1:0]       aluResult;
	logic [`XLEN-1:0]       storeData;
	logic                   branchTaken;
	logic [`XLEN-1:0]       branchTarget;
	logic [`XLEN-1:0]       wbValue;

	assign pcPlus4  = pc + `XLEN'(4);
	assign imemAddr = pc;

	// Flush beats stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (flush) begin
			pc <= branchTarget;
		end else if (!stall) begin
			pc <= pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decReg <= '0;
		end else if (flush) begin
			decReg <= '0;
		end else if (!stall) begin
			decReg <= '{instr: imemData, pcPlus4: pcPlus4};
		end
	end

	assign decRs = decReg.instr[25:21];
	assign decRt = decReg.instr[20:16];

	decodeControl decoder (
		.instr     (decReg.instr),
		.ctrl      (decCtrl),
		.immediate (decImm)
	);

	regFile regs (
		.clk       (clk),
		.rstN      (rstN),
		.writeEn   (wbReg.ctrl.regWrite),
		.writeAddr (wbReg.ctrl.destReg),
		.writeData (wbValue),
		.readAddrA (decRs),
		.readAddrB (decRt),
		.readDataA (rsVal),
		.readDataB (rtVal)
	);

	always_comb begin
		exNext.ctrl    = decCtrl;
		exNext.rs      = decRs;
		exNext.rt      = decRt;
		exNext.rsVal   = rsVal;
		exNext.rtVal   = rtVal;
		exNext.imm     = decImm;
		exNext.pcPlus4 = decReg.pcPlus4;
	end

	// A stall or a taken branch sends a bubble into execute
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exReg <= '0;
		end else if (flush || stall) begin
			exReg <= '0;
		end else begin
			exReg <= exNext;
		end
	end

	hazardUnit hazards (
		.decodeRs    (decRs),
		.decodeRt    (decRt),
		.execute     (exReg),
		.memCtrl     (memReg.ctrl),
		.wbCtrl      (wbReg.ctrl),
		.branchTaken (branchTaken),
		.fwdA        (fwdA),
		.fwdB        (fwdB),
		.stall       (stall),
		.flush       (flush)
	);

	executeStage execUnit (
		.execute      (exReg),
		.fwdA         (fwdA),
		.fwdB         (fwdB),
		.memResult    (memReg.aluResult),
		.wbResult     (wbValue),
		.aluResult    (aluResult),
		.storeData    (storeData),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget)
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memReg <= '0;
			wbReg  <= '0;
		end else begin
			memReg <= '{ctrl: exReg.ctrl, aluResult: aluResult, storeData: storeData};
			wbReg  <= '{ctrl: memReg.ctrl, aluResult: memReg.aluResult, loadData: dataRdata};
		end
	end

	assign dataAddr  = memReg.aluResult;
	assign dataWdata = memReg.storeData;
	assign dataWrite = memReg.ctrl.memWrite;

	assign wbValue = wbReg.ctrl.memRead ? wbReg.loadData : wbReg.aluResult;

	// Only a load that writes a register may hold decode
	stallOnLoad: assert property (@(posedge clk) disable iff (!rstN)
		stall |-> (exReg.ctrl.memRead && exReg.ctrl.regWrite && !exReg.ctrl.memWrite));

	// The stall keeps every consumer of a load off the memory stage result
	noLoadForward: assert property (@(posedge clk) disable iff (!rstN)
		memReg.ctrl.memRead |-> (fwdA != fwdMem && fwdB != fwdMem));

endmodule

//--- mipsPkg.sv
`include "core_settings.svh"

package mipsPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddiu = 6'h09,
		opOri   = 6'h0d,
		opLui   = 6'h0f,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpT;

	// Operand source for the execute stage
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSelT;

	// All zero means a bubble
	typedef struct packed {
		aluOpT                  aluOp;
		logic                   useImm;
		logic                   regWrite;
		logic                   memRead;
		logic                   memWrite;
		logic                   isBranch;
		logic [`REG_ADDR_W-1:0] destReg;
	} ctrlT;

	typedef struct packed {
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] pcPlus4;
	} decodeRegT;

	typedef struct packed {
		ctrlT                   ctrl;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`XLEN-1:0]       rsVal;
		logic [`XLEN-1:0]       rtVal;
		logic [`XLEN-1:0]       imm;
		logic [`XLEN-1:0]       pcPlus4;
	} executeRegT;

	typedef struct packed {
		ctrlT             ctrl;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] storeData;
	} memoryRegT;

	typedef struct packed {
		ctrlT             ctrl;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] loadData;
	} writebackRegT;

endpackage

//--- program.hex
// One 32-bit instruction word per line in hex, starting at address 0
// The mnemonic after each word is its assembly form
24011234  // addiu $1, $0, 0x1234
342200f0  // ori   $2, $1, 0x00f0
3c038001  // lui   $3, 0x8001
00432021  // addu  $4, $2, $3
00812823  // subu  $5, $4, $1
00a23024  // and   $6, $5, $2
00c33825  // or    $7, $6, $3
0061402a  // slt   $8, $3, $1
ac080008  // sw    $8, 8($0)
ac04000c  // sw    $4, 12($0)
ac050010  // sw    $5, 16($0)
ac060014  // sw    $6, 20($0)
ac070018  // sw    $7, 24($0)
24000005  // addiu $0, $0, 5
ac00001c  // sw    $0, 28($0)
8c090000  // lw    $9, 0($0)
01205021  // addu  $10, $9, $0
8c0b0004  // lw    $11, 4($0)
016a6021  // addu  $12, $11, $10
ac0c0020  // sw    $12, 32($0)
240d0bad  // addiu $13, $0, 0x0bad
10000002  // beq   $0, $0, +2
ac0d0028  // sw    $13, 40($0)
ac0d002c  // sw    $13, 44($0)
10200001  // beq   $1, $0, +1
ac010030  // sw    $1, 48($0)
1000ffff  // beq   $0, $0, -1
00000000  // nop fetched behind the final loop
00000000  // nop

//--- regFile.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module regFile (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   writeEn,
	input  logic [`REG_ADDR_W-1:0] writeAddr,
	input  logic [`XLEN-1:0]       writeData,
	input  logic [`REG_ADDR_W-1:0] readAddrA,
	input  logic [`REG_ADDR_W-1:0] readAddrB,
	output logic [`XLEN-1:0]       readDataA,
	output logic [`XLEN-1:0]       readDataB
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic             writeLive;

	// Register zero is never written
	assign writeLive = writeEn && (writeAddr != '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeLive) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Same-cycle write is visible to decode
	assign readDataA = (writeLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writeLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

	zeroReadA: assert property (@(posedge clk) disable iff (!rstN)
		(readAddrA == '0) |-> (readDataA == '0));
	zeroReadB: assert property (@(posedge clk) disable iff (!rstN)
		(readAddrB == '0) |-> (readDataB == '0));

endmodule

//--- sim.f
+incdir+.
mipsPkg.sv
regFile.sv
decodeControl.sv
executeStage.sv
hazardUnit.sv
mipsPipeline.sv
tbMips.sv

//--- tbMips.sv
`timescale 1ns/1ns
`include "core_settings.svh"

module tbMips;

	localparam int DoneTimeout = 200;
	localparam int QuietCycles = 20;
	localparam logic [`XLEN-1:0] MarkerValue = 32'h0000_0bad;

	logic             clk;
	logic             rstN;
	logic [`XLEN-1:0] imemAddr;
	logic [`XLEN-1:0] imemData;
	logic [`XLEN-1:0] dataAddr;
	logic [`XLEN-1:0] dataWdata;
	logic             dataWrite;
	logic [`XLEN-1:0] dataRdata;

	logic [`XLEN-1:0] imem [32];
	logic [`XLEN-1:0] dmem [64];
	logic [`XLEN-1:0] expAddr [$];
	logic [`XLEN-1:0] expData [$];
	int               storeIdx = 0;
	integer           seed;

	mipsPipeline uut (
		.clk       (clk),
		.rstN      (rstN),
		.imemAddr  (imemAddr),
		.imemData  (imemData),
		.dataAddr  (dataAddr),
		.dataWdata (dataWdata),
		.dataWrite (dataWrite),
		.dataRdata (dataRdata)
	);

	always #4 clk = ~clk;

	// Both memories answer in the same cycle
	assign imemData  = imem[imemAddr[6:2]];
	assign dataRdata = dmem[dataAddr[7:2]];

	always @(posedge clk) begin
		if (dataWrite) begin
			dmem[dataAddr[7:2]] <= dataWdata;
		end
		if (rstN && dataWrite) begin
			storeIdx <= storeIdx + 1;
		end
	end

	task automatic stopOnFailure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [`XLEN-1:0] got,
		input logic [`XLEN-1:0] expected);
		$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
		stopOnFailure();
	endtask

	task automatic expectStore(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// Register values follow the ISA rules for each instruction of program.hex
	task automatic buildStoreTable(input logic [`XLEN-1:0] word0, input logic [`XLEN-1:0] word1);
		logic [`XLEN-1:0] r1, r2, r3, r4, r5, r6, r7, r8;
		r1 = 32'h0000_1234;
		r2 = r1 | 32'h0000_00f0;
		r3 = 32'h0000_8001 << 16;
		r4 = r2 + r3;
		r5 = r4 - r1;
		r6 = r5 & r2;
		r7 = r6 | r3;
		r8 = ($signed(r3) < $signed(r1)) ? 32'd1 : 32'd0;
		expectStore(32'd8, r8);
		expectStore(32'd12, r4);
		expectStore(32'd16, r5);
		expectStore(32'd20, r6);
		expectStore(32'd24, r7);
		// Register zero stays zero after the addiu to it
		expectStore(32'd28, 32'd0);
		expectStore(32'd32, word0 + word1);
		// Only the not-taken beq path stores here
		expectStore(32'd48, r1);
	endtask

	// Outputs change on the rising edge, so the falling edge sees them settled
	resetQuiet: assert property (@(negedge clk) !rstN |-> !dataWrite)
		else reportMismatch("dataWrite", `XLEN'(dataWrite), '0);
	resetPc: assert property (@(negedge clk) !rstN |-> (imemAddr == `RESET_PC))
		else reportMismatch("imemAddr", imemAddr, `RESET_PC);
	// The first fetch after reset still comes from the reset address
	resetExit: assert property (@(posedge clk) $rose(rstN) |-> (imemAddr == `RESET_PC))
		else reportMismatch("imemAddr", $sampled(imemAddr), `RESET_PC);
	storeAddr: assert property (@(negedge clk) disable iff (!rstN)
		(dataWrite && storeIdx < expAddr.size()) |-> (dataAddr == expAddr[storeIdx]))
		else reportMismatch("dataAddr", dataAddr, expAddr[storeIdx]);
	storeValue: assert property (@(negedge clk) disable iff (!rstN)
		(dataWrite && storeIdx < expData.size()) |-> (dataWdata == expData[storeIdx]))
		else reportMismatch("dataWdata", dataWdata, expData[storeIdx]);
	storeCount: assert property (@(negedge clk) disable iff (!rstN)
		dataWrite |-> (storeIdx < expAddr.size()))
		else begin
			$display("A store appeared after all %0d expected stores", expAddr.size());
			stopOnFailure();
		end
	noMarker: assert property (@(negedge clk) disable iff (!rstN)
		dataWrite |-> (dataWdata != MarkerValue))
		else begin
			$display("A store behind a taken branch reached the data port at %0t", $time);
			stopOnFailure();
		end

	initial begin
		int cycles;
		clk  = 1'b0;
		rstN = 1'b0;
		seed = 32'ha27d;
		$readmemh("program.hex", imem);
		for (int i = 0; i < 64; i++) begin
			dmem[i[5:0]] = 32'hd0d0_0000 | i;
		end
		dmem[0] = $random(seed);
		dmem[1] = $random(seed);
		buildStoreTable(dmem[0], dmem[1]);
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		cycles = 0;
		while (storeIdx < expAddr.size() && cycles < DoneTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (storeIdx < expAddr.size()) begin
			$display("Timed out after %0d cycles with %0d of %0d stores seen",
				cycles, storeIdx, expAddr.size());
			stopOnFailure();
		end else begin
			// The core now spins in its final loop and must stay off the data port
			repeat (QuietCycles) @(negedge clk);
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule
